/* verilog/slice_cfg_pkg.sv */
// ****************************************
// slice configuration
// widths, counts and vector types shared by
// the two-lane execution slice
// ****************************************

`default_nettype none

package slice_cfg_pkg;

  // issue lanes, one write port and one ram bank each
  localparam int unsigned NR_LANES  = 2;
  // two read ports per lane, rs1 then rs2
  localparam int unsigned NR_RPORTS = 2 * NR_LANES;

  localparam int unsigned XLEN      = 32;
  localparam int unsigned REG_AW    = 5;
  localparam int unsigned NR_REGS   = 32;
  // bank index width in the live value table
  localparam int unsigned LVT_W     = 1;
  // shift amount bits taken from operand b
  localparam int unsigned SHAMT_W   = 5;

  typedef logic [XLEN-1:0]   data_t;
  typedef logic [REG_AW-1:0] reg_addr_t;
  typedef logic [LVT_W-1:0]  bank_sel_t;

endpackage

`default_nettype wire

/* verilog/slice_isa_pkg.sv */
// ****************************************
// slice instruction set
// opcodes, instruction word layout and the
// records passed between pipeline stages
// ****************************************

`default_nettype none

package slice_isa_pkg;

  import slice_cfg_pkg::*;

  localparam int unsigned IMM_W = 12;

  typedef logic [IMM_W-1:0] imm_t;

  // codes 9 to 15 are unused and decode as not valid
  typedef enum logic [3:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_AND = 4'd2,
    OP_OR  = 4'd3,
    OP_XOR = 4'd4,
    OP_SLL = 4'd5,
    OP_SRL = 4'd6,
    OP_SLT = 4'd7,
    OP_LI  = 4'd8
  } alu_op_e;

  // 32-bit instruction word, msb first
  typedef struct packed {
    alu_op_e   op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    // signed immediate, only used by OP_LI
    imm_t      imm;
    logic      spare;
  } instr_t;

  // decode to execute
  typedef struct packed {
    logic      valid;
    alu_op_e   op;
    reg_addr_t rd;
    data_t     a;
    data_t     b;
  } dec_op_t;

  // execute to result, result to write port and top
  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    data_t     data;
  } commit_t;

endpackage

`default_nettype wire

/* verilog/regfile_lvt.sv */
// ****************************************
// lvt register file
// one distributed-ram bank per write port,
// async reads steered by a live value table
// ****************************************

`timescale 1ns/10ps
`default_nettype none

module regfile_lvt
  import slice_cfg_pkg::*;
  import slice_isa_pkg::*;
(
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  // read ports, rs1 and rs2 of each lane
  input  wire reg_addr_t [NR_RPORTS-1:0]    raddr_i,
  output      data_t     [NR_RPORTS-1:0]    rdata_o,
  // write ports, one per lane
  input  wire logic      [NR_LANES-1:0]     we_i,
  input  wire reg_addr_t [NR_LANES-1:0]     waddr_i,
  input  wire data_t     [NR_LANES-1:0]     wdata_i
);

  // write qualified by a non-zero address
  logic [NR_LANES-1:0] wr_en;

  // bank that holds the live copy of each register
  bank_sel_t [NR_REGS-1:0] lvt_d;
  bank_sel_t [NR_REGS-1:0] lvt_q;

  // raw read data of every bank on every read port
  data_t [NR_RPORTS-1:0] bank_rdata [NR_LANES];

  always_comb begin
    for (int j = 0; j < NR_LANES; j++) begin
      wr_en[j] = we_i[j] && (waddr_i[j] != '0);
    end
  end

  // table update
  // later ports overwrite earlier ones, so the highest index wins a conflict
  always_comb begin
    lvt_d = lvt_q;
    for (int j = 0; j < NR_LANES; j++) begin
      if (wr_en[j]) begin
        lvt_d[waddr_i[j]] = bank_sel_t'(j);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lvt_q <= '0;
    end else begin
      lvt_q <= lvt_d;
    end
  end

  // ram banks
  for (genvar j = 0; j < NR_LANES; j++) begin : g_bank
    // contents come up undefined, the testbench preloads them
    data_t mem_q [NR_REGS];

    // single sync write port per bank
    always_ff @(posedge clk_i) begin
      if (wr_en[j]) begin
        mem_q[waddr_i[j]] <= wdata_i[j];
      end
    end

    // async reads, one per read port
    for (genvar k = 0; k < NR_RPORTS; k++) begin : g_rd
      assign bank_rdata[j][k] = mem_q[raddr_i[k]];
    end

    // result stage must already have dropped writes to register 0
    a_no_wr_x0 : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      we_i[j] |-> (waddr_i[j] != '0)
    ) else $error("write enable with address 0 on port %0d", j);
  end

  // output mux
  // register 0 reads as zero whatever the banks hold
  always_comb begin
    for (int k = 0; k < NR_RPORTS; k++) begin
      if (raddr_i[k] == '0) begin
        rdata_o[k] = '0;
      end else begin
        rdata_o[k] = bank_rdata[lvt_q[raddr_i[k]]][k];
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/issue_decode.sv */
// ****************************************
// issue and decode stage
// reads operands, selects the immediate and
// registers the decoded op of each lane
// ****************************************

`timescale 1ns/10ps
`default_nettype none

module issue_decode
  import slice_cfg_pkg::*;
  import slice_isa_pkg::*;
(
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  // issue side
  input  wire logic    [NR_LANES-1:0]    issue_valid_i,
  input  wire instr_t  [NR_LANES-1:0]    issue_instr_i,
  // register file read ports
  output      reg_addr_t [NR_RPORTS-1:0] raddr_o,
  input  wire data_t     [NR_RPORTS-1:0] rdata_i,
  // to execute
  output      dec_op_t [NR_LANES-1:0]    dec_o
);

  dec_op_t [NR_LANES-1:0] dec_d;
  dec_op_t [NR_LANES-1:0] dec_q;

  // true for the nine defined opcodes
  function automatic logic op_known(alu_op_e op);
    case (op)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
      OP_SLL, OP_SRL, OP_SLT, OP_LI: op_known = 1'b1;
      default:                       op_known = 1'b0;
    endcase
  endfunction

  // read addresses
  // port 2l carries rs1, port 2l+1 carries rs2
  always_comb begin
    for (int l = 0; l < NR_LANES; l++) begin
      raddr_o[2*l]   = issue_instr_i[l].rs1;
      raddr_o[2*l+1] = issue_instr_i[l].rs2;
    end
  end

  // operand select
  always_comb begin
    for (int l = 0; l < NR_LANES; l++) begin
      dec_d[l].valid = issue_valid_i[l] && op_known(issue_instr_i[l].op);
      dec_d[l].op    = issue_instr_i[l].op;
      dec_d[l].rd    = issue_instr_i[l].rd;
      dec_d[l].b     = rdata_i[2*l+1];
      if (issue_instr_i[l].op == OP_LI) begin
        // sign-extended immediate replaces rs1
        dec_d[l].a = {{(XLEN-IMM_W){issue_instr_i[l].imm[IMM_W-1]}}, issue_instr_i[l].imm};
      end else begin
        dec_d[l].a = rdata_i[2*l];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_q <= '0;
    end else begin
      dec_q <= dec_d;
    end
  end

  assign dec_o = dec_q;

  for (genvar l = 0; l < NR_LANES; l++) begin : g_chk
    a_op_known : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      dec_q[l].valid |-> (dec_q[l].op inside {[OP_ADD:OP_LI]})
    ) else $error("lane %0d holds undefined opcode", l);
  end

endmodule

`default_nettype wire

/* verilog/alu_execute.sv */
// ****************************************
// execute stage
// per-lane alu, result registered with its
// destination register
// ****************************************

`timescale 1ns/10ps
`default_nettype none

module alu_execute
  import slice_cfg_pkg::*;
  import slice_isa_pkg::*;
(
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  // from decode
  input  wire dec_op_t [NR_LANES-1:0]  dec_i,
  // to result stage
  output      commit_t [NR_LANES-1:0]  exe_o
);

  commit_t [NR_LANES-1:0] exe_d;
  commit_t [NR_LANES-1:0] exe_q;

  function automatic data_t alu_calc(alu_op_e op, data_t a, data_t b);
    logic lt;
    lt = $signed(a) < $signed(b);
    case (op)
      OP_ADD:  alu_calc = a + b;
      OP_SUB:  alu_calc = a - b;
      OP_AND:  alu_calc = a & b;
      OP_OR:   alu_calc = a | b;
      OP_XOR:  alu_calc = a ^ b;
      // shift amount from the low bits of b
      OP_SLL:  alu_calc = a << b[SHAMT_W-1:0];
      OP_SRL:  alu_calc = a >> b[SHAMT_W-1:0];
      // signed compare, yields 1 or 0
      OP_SLT:  alu_calc = {{(XLEN-1){1'b0}}, lt};
      // immediate already sits in operand a
      OP_LI:   alu_calc = a;
      default: alu_calc = '0;
    endcase
  endfunction

  // rd 0 results still travel so they show on the commit port
  always_comb begin
    for (int l = 0; l < NR_LANES; l++) begin
      exe_d[l].valid = dec_i[l].valid;
      exe_d[l].rd    = dec_i[l].rd;
      exe_d[l].data  = alu_calc(dec_i[l].op, dec_i[l].a, dec_i[l].b);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exe_q <= '0;
    end else begin
      exe_q <= exe_d;
    end
  end

  assign exe_o = exe_q;

endmodule

`default_nettype wire

/* verilog/commit_result.sv */
// ****************************************
// result stage
// registers commits, drives write ports and
// the top commit outputs
// ****************************************

`timescale 1ns/10ps
`default_nettype none

module commit_result
  import slice_cfg_pkg::*;
  import slice_isa_pkg::*;
(
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  // from execute
  input  wire commit_t   [NR_LANES-1:0]   exe_i,
  // register file write ports
  output      logic      [NR_LANES-1:0]   we_o,
  output      reg_addr_t [NR_LANES-1:0]   waddr_o,
  output      data_t     [NR_LANES-1:0]   wdata_o,
  // top commit report
  output      commit_t   [NR_LANES-1:0]   commit_o
);

  commit_t [NR_LANES-1:0] commit_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      commit_q <= '0;
    end else begin
      commit_q <= exe_i;
    end
  end

  // fan out to the write ports
  // writes to register 0 are dropped here
  always_comb begin
    for (int l = 0; l < NR_LANES; l++) begin
      we_o[l]    = commit_q[l].valid && (commit_q[l].rd != '0);
      waddr_o[l] = commit_q[l].rd;
      wdata_o[l] = commit_q[l].data;
    end
  end

  assign commit_o = commit_q;

  for (genvar l = 0; l < NR_LANES; l++) begin : g_chk
    a_valid_known : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      !$isunknown(commit_o[l].valid)
    ) else $error("commit valid unknown on lane %0d", l);
  end

endmodule

`default_nettype wire

/* verilog/alu_slice_top.sv */
// ****************************************
// two-lane alu slice
// decode, lvt register file, execute and
// result stage wired together
// ****************************************

`timescale 1ns/10ps
`default_nettype none

module alu_slice_top
  import slice_cfg_pkg::*;
  import slice_isa_pkg::*;
(
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic    [NR_LANES-1:0]  issue_valid_i,
  input  wire instr_t  [NR_LANES-1:0]  issue_instr_i,
  output      commit_t [NR_LANES-1:0]  commit_o
);

  // operand reads
  reg_addr_t [NR_RPORTS-1:0] raddr;
  data_t     [NR_RPORTS-1:0] rdata;

  // pipeline records
  dec_op_t   [NR_LANES-1:0]  dec_q;
  commit_t   [NR_LANES-1:0]  exe_q;

  // write back
  logic      [NR_LANES-1:0]  we;
  reg_addr_t [NR_LANES-1:0]  waddr;
  data_t     [NR_LANES-1:0]  wdata;

  issue_decode i_decode (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_valid_i (issue_valid_i),
    .issue_instr_i (issue_instr_i),
    .raddr_o       (raddr),
    .rdata_i       (rdata),
    .dec_o         (dec_q)
  );

  regfile_lvt i_regfile (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .raddr_i (raddr),
    .rdata_o (rdata),
    .we_i    (we),
    .waddr_i (waddr),
    .wdata_i (wdata)
  );

  alu_execute i_execute (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .dec_i  (dec_q),
    .exe_o  (exe_q)
  );

  commit_result i_result (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .exe_i    (exe_q),
    .we_o     (we),
    .waddr_o  (waddr),
    .wdata_o  (wdata),
    .commit_o (commit_o)
  );

endmodule

`default_nettype wire

/* tb/alu_slice_tb.sv */
// ****************************************
// alu slice testbench
// directed and random issue checked against
// a delayed shadow register file
// ****************************************

`timescale 1ns/10ps
`default_nettype none

module alu_slice_tb
  import slice_cfg_pkg::*;
  import slice_isa_pkg::*;
();

  typedef commit_t [NR_LANES-1:0] lanes_t;

  // reset, six tests with their drain cycles, then a margin
  localparam int unsigned MAX_CYC = 8 + 37 + 53 + 10 + 10 + 10 + 30 + 40;

  logic                   clk_i;
  logic                   rst_ni;
  logic    [NR_LANES-1:0] issue_valid;
  instr_t  [NR_LANES-1:0] issue_instr;
  commit_t [NR_LANES-1:0] commit;

  // reference state
  data_t       shadow [NR_REGS];
  lanes_t      exp_q [$];
  int unsigned due_q [$];
  lanes_t      wr_q [$];
  int unsigned wr_cyc_q [$];
  int unsigned cyc;
  int unsigned chk_cnt;
  int unsigned err_cnt;
  int unsigned test_err0;
  logic [31:0] lfsr;
  string       test_name;

  alu_slice_top UUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_valid_i (issue_valid),
    .issue_instr_i (issue_instr),
    .commit_o      (commit)
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rand_bits(int unsigned n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) lfsr = lfsr ^ 32'h8020_0003;
      r = {r[30:0], b};
    end
    return r;
  endfunction

  function automatic instr_t make_instr(alu_op_e op, int rd, int rs1, int rs2, imm_t imm);
    instr_t ins;
    ins.op    = op;
    ins.rd    = reg_addr_t'(rd);
    ins.rs1   = reg_addr_t'(rs1);
    ins.rs2   = reg_addr_t'(rs2);
    ins.imm   = imm;
    ins.spare = 1'b0;
    return ins;
  endfunction

  function automatic instr_t rand_instr();
    alu_op_e op;
    op = alu_op_e'(rand_bits(4) % 9);
    return make_instr(op, rand_bits(5), rand_bits(5), rand_bits(5), imm_t'(rand_bits(12)));
  endfunction

  // expected result from the opcode rules
  function automatic data_t ref_alu(instr_t ins, data_t a, data_t b);
    case (ins.op)
      OP_ADD:  return a + b;
      OP_SUB:  return a + ~b + 1;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLL:  return a << b[4:0];
      OP_SRL:  return a >> b[4:0];
      // with differing signs a is less only when negative
      OP_SLT:  return (a[31] != b[31]) ? data_t'(a[31]) : data_t'(a < b);
      OP_LI:   return data_t'($signed(ins.imm));
      default: return '0;
    endcase
  endfunction

  // one issue cycle with the model updated at the same edge
  task automatic drive(logic [NR_LANES-1:0] v, instr_t i0, instr_t i1);
    instr_t [NR_LANES-1:0] ins;
    lanes_t want;
    lanes_t wr;
    @(posedge clk_i);
    ins = {i1, i0};
    // writes land four drive edges later and lane 1 goes after lane 0
    while (wr_cyc_q.size() > 0 && wr_cyc_q[0] + 4 <= cyc) begin
      wr = wr_q.pop_front();
      void'(wr_cyc_q.pop_front());
      for (int l = 0; l < NR_LANES; l++) begin
        if (wr[l].valid && wr[l].rd != '0) shadow[wr[l].rd] = wr[l].data;
      end
    end
    for (int l = 0; l < NR_LANES; l++) begin
      want[l].valid = v[l];
      want[l].rd    = ins[l].rd;
      want[l].data  = ref_alu(ins[l], shadow[ins[l].rs1], shadow[ins[l].rs2]);
    end
    exp_q.push_back(want);
    due_q.push_back(cyc + 4);
    wr_q.push_back(want);
    wr_cyc_q.push_back(cyc);
    issue_valid <= v;
    issue_instr <= ins;
  endtask

  task automatic idle(int n);
    repeat (n) drive('0, '0, '0);
  endtask

  // copy every register onto itself so each commit shows its value
  task automatic copy_all();
    for (int r = 1; r < NR_REGS; r += 2) begin
      drive({r + 1 < NR_REGS, 1'b1}, make_instr(OP_ADD, r, r, 0, '0),
            make_instr(OP_ADD, r + 1, r + 1, 0, '0));
    end
  endtask

  task automatic end_test();
    idle(5);
    $display("test %s finished with %0d errors", test_name, err_cnt - test_err0);
    test_err0 = err_cnt;
  endtask

  // compare in the middle of the cycle the commit is visible
  always @(negedge clk_i) begin
    lanes_t want;
    while (due_q.size() > 0 && due_q[0] == cyc) begin
      want = exp_q.pop_front();
      void'(due_q.pop_front());
      for (int l = 0; l < NR_LANES; l++) begin
        chk_cnt++;
        if (want[l].valid && commit[l].valid !== 1'b1) begin
          err_cnt++;
          $display("%s: lane %0d did not commit an issued instruction", test_name, l);
        end else if (!want[l].valid && commit[l].valid !== 1'b0) begin
          err_cnt++;
          $display("%s: lane %0d committed without an issue", test_name, l);
        end else if (want[l].valid && (commit[l].rd !== want[l].rd ||
                                       commit[l].data !== want[l].data)) begin
          err_cnt++;
          $display("[ERROR] %s lane %0d: expected rd %0d data %h, actual rd %0d data %h",
                   test_name, l, want[l].rd, want[l].data, commit[l].rd, commit[l].data);
        end
      end
    end
  end

  initial begin
    wait (cyc >= MAX_CYC);
    $display("timeout: run did not finish within %0d cycles", MAX_CYC);
    $display("Checks failed");
    $finish;
  end

  initial begin
    rst_ni      = 1'b0;
    cyc         = 0;
    lfsr        = 32'd82;
    chk_cnt     = 0;
    err_cnt     = 0;
    test_err0   = 0;
    issue_valid = '0;
    issue_instr = '0;
    for (int r = 0; r < NR_REGS; r++) shadow[r] = '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    test_name = "load";
    for (int r = 1; r < NR_REGS; r += 2) begin
      drive({r + 1 < NR_REGS, 1'b1}, make_instr(OP_LI, r, 0, 0, imm_t'(rand_bits(12))),
            make_instr(OP_LI, r + 1, 0, 0, imm_t'(rand_bits(12))));
    end
    copy_all();
    end_test();

    test_name = "alu_random";
    repeat (48) drive(2'b11, rand_instr(), rand_instr());
    end_test();

    // same rd on both lanes and a read four cycles on
    test_name = "write_conflict";
    drive(2'b11, make_instr(OP_LI, 7, 0, 0, 12'h123), make_instr(OP_LI, 7, 0, 0, 12'h9a6));
    idle(3);
    drive(2'b01, make_instr(OP_ADD, 8, 7, 0, '0), '0);
    end_test();

    test_name = "reg_zero";
    drive(2'b11, make_instr(OP_LI, 0, 0, 0, 12'h7ff), make_instr(OP_ADD, 0, 3, 4, '0));
    idle(3);
    drive(2'b11, make_instr(OP_ADD, 9, 0, 0, '0), make_instr(OP_OR, 10, 0, 5, '0));
    end_test();

    // readers one to four cycles behind the writer
    test_name = "visibility";
    drive(2'b01, make_instr(OP_LI, 11, 0, 0, 12'h5a5), '0);
    repeat (4) drive(2'b10, '0, make_instr(OP_ADD, 12, 11, 0, '0));
    end_test();

    // idle lane carries a random instruction that must not write
    test_name = "single_lane";
    repeat (3) begin
      drive(2'b01, rand_instr(), rand_instr());
      drive(2'b10, rand_instr(), rand_instr());
    end
    idle(3);
    copy_all();
    end_test();

    $display("%0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
verilog/slice_cfg_pkg.sv
verilog/slice_isa_pkg.sv
verilog/regfile_lvt.sv
verilog/issue_decode.sv
verilog/alu_execute.sv
verilog/commit_result.sv
verilog/alu_slice_top.sv
tb/alu_slice_tb.sv
